/* alu.sv */
`timescale 1ns/10ps
`include "rv_core_defs.svh"

module alu import rv_core_pkg::*; (
	input  logic [`OP_BUS_W-1:0] op_bus,
	input  logic [`XLEN-1:0]     a,
	input  logic [`XLEN-1:0]     b,   // rs2 or imm, chosen upstream
	output logic [`XLEN-1:0]     result
);

	logic [4:0] shamt;

	assign shamt = b[4:0];

	// register and immediate forms share one datapath
	always_comb begin
		if (op_bus[op_add] | op_bus[op_addi]) begin
			result = a + b;
		end else if (op_bus[op_sub]) begin
			result = a - b;
		end else if (op_bus[op_xor] | op_bus[op_xori]) begin
			result = a ^ b;
		end else if (op_bus[op_or] | op_bus[op_ori]) begin
			result = a | b;
		end else if (op_bus[op_and] | op_bus[op_andi]) begin
			result = a & b;
		end else if (op_bus[op_sll] | op_bus[op_slli]) begin
			result = a << shamt;
		end else if (op_bus[op_srl] | op_bus[op_srli]) begin
			result = a >> shamt;
		end else if (op_bus[op_sra] | op_bus[op_srai]) begin
			result = $unsigned($signed(a) >>> shamt);
		end else if (op_bus[op_slt] | op_bus[op_slti]) begin
			result = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
		end else if (op_bus[op_sltu] | op_bus[op_sltiu]) begin
			result = {{(`XLEN-1){1'b0}}, a < b};
		end else begin
			result = '0; // not an alu op
		end
	end

endmodule

/* exec_bus_if.sv */
`timescale 1ns/10ps
`include "rv_core_defs.svh"

interface exec_bus_if import rv_core_pkg::*; ();

	opcode_e               opcode;
	logic [`OP_BUS_W-1:0] op_bus;   // one-hot decoded operation
	logic [`XLEN-1:0]     imm;      // already sign extended / shifted
	logic [`XLEN-1:0]     pc;
	logic [`REG_AW-1:0]   rs1_addr;
	logic [`REG_AW-1:0]   rs2_addr;
	logic [`REG_AW-1:0]   rd_addr;
	logic [`XLEN-1:0]     rs1_val;
	logic [`XLEN-1:0]     rs2_val;

	modport dec (
		output opcode, op_bus, imm, pc, rs1_addr, rs2_addr, rd_addr
	);

	modport rf (
		input  rs1_addr, rs2_addr,
		output rs1_val, rs2_val
	);

	modport exe (
		input opcode, op_bus, imm, pc, rs1_addr, rs2_addr, rd_addr,
		input rs1_val, rs2_val
	);

endinterface

/* exec_control.sv */
`timescale 1ns/10ps
`include "rv_core_defs.svh"

module exec_control import rv_core_pkg::*; (
	input  logic              clk,
	input  logic              reset,
	input  logic              phase,       // 0 execute, 1 write-back
	exec_bus_if.exe           bus,
	input  logic [`XLEN-1:0]  dmem_rdata,
	output logic [`XLEN-1:0]  dmem_addr,
	output logic [`XLEN-1:0]  dmem_wdata,
	output logic [3:0]        dmem_be,
	output logic              dmem_we,
	output logic              jump,
	output logic [`XLEN-1:0]  jump_target,
	output logic              rf_we,
	output logic [`XLEN-1:0]  rd_data,
	output logic              retire
);

	logic [`XLEN-1:0] alu_b;
	logic [`XLEN-1:0] alu_y;
	logic [`XLEN-1:0] addr_sum;
	logic [`XLEN-1:0] link_pc;
	logic [`XLEN-1:0] wb_q;
	logic [`XLEN-1:0] byte_sh;
	logic [`XLEN-1:0] half_sh;
	logic [`XLEN-1:0] load_val;
	logic [4:0]       ld_sel_q;   // lhu lbu lw lh lb
	logic [1:0]       off;
	logic             eq;
	logic             lt_s;
	logic             lt_u;
	logic             taken;
	logic             writes_rd;

	assign alu_b = (bus.opcode == opc_op_imm) ? bus.imm : bus.rs2_val;

	alu alu0 (
		.op_bus (bus.op_bus),
		.a      (bus.rs1_val),
		.b      (alu_b),
		.result (alu_y)
	);

	assign addr_sum = bus.rs1_val + bus.imm; // loads, stores, jalr
	assign link_pc  = bus.pc + `XLEN'd4;

	assign eq   = (bus.rs1_val == bus.rs2_val);
	assign lt_s = ($signed(bus.rs1_val) < $signed(bus.rs2_val));
	assign lt_u = (bus.rs1_val < bus.rs2_val);

	assign taken = (bus.op_bus[op_beq] & eq) | (bus.op_bus[op_bne] & ~eq) |
		(bus.op_bus[op_blt] & lt_s) | (bus.op_bus[op_bge] & ~lt_s) |
		(bus.op_bus[op_bltu] & lt_u) | (bus.op_bus[op_bgeu] & ~lt_u);

	assign writes_rd = (|bus.op_bus[op_sltiu:op_add]) | (|bus.op_bus[op_lhu:op_lb]) |
		bus.op_bus[op_jal] | bus.op_bus[op_jalr] | bus.op_bus[op_lui] | bus.op_bus[op_auipc];

	// strobes set at the execute edge, dropped at the write-back edge
	always_ff @(posedge clk) begin
		if (reset) begin
			rf_we    <= 1'b0;
			dmem_we  <= 1'b0;
			jump     <= 1'b0;
			retire   <= 1'b0;
			ld_sel_q <= '0;
		end else if (!phase) begin
			retire   <= 1'b1;
			rf_we    <= writes_rd && (bus.rd_addr != '0);
			dmem_we  <= |bus.op_bus[op_sw:op_sb];
			jump     <= taken | bus.op_bus[op_jal] | bus.op_bus[op_jalr];
			ld_sel_q <= bus.op_bus[op_lhu:op_lb];
		end else begin
			retire  <= 1'b0;
			rf_we   <= 1'b0;
			dmem_we <= 1'b0;
			jump    <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (!phase) begin
			dmem_addr   <= addr_sum;
			jump_target <= bus.op_bus[op_jalr] ? {addr_sum[`XLEN-1:1], 1'b0} : bus.pc + bus.imm;
			// byte lanes follow the low address bits
			if (bus.op_bus[op_sb]) begin
				dmem_be    <= 4'b0001 << addr_sum[1:0];
				dmem_wdata <= {24'b0, bus.rs2_val[7:0]} << {addr_sum[1:0], 3'b000};
			end else if (bus.op_bus[op_sh]) begin
				dmem_be    <= 4'b0011 << {addr_sum[1], 1'b0};
				dmem_wdata <= {16'b0, bus.rs2_val[15:0]} << {addr_sum[1], 4'b0000};
			end else if (bus.op_bus[op_sw]) begin
				dmem_be    <= 4'b1111;
				dmem_wdata <= bus.rs2_val;
			end else begin
				dmem_be    <= 4'b0000;
				dmem_wdata <= bus.rs2_val;
			end
			case (bus.opcode)
				opc_lui:           wb_q <= bus.imm;
				opc_auipc:         wb_q <= bus.pc + bus.imm;
				opc_jal, opc_jalr: wb_q <= link_pc;
				default:           wb_q <= alu_y;
			endcase
		end
	end

	// load data arrives during write-back
	assign off     = dmem_addr[1:0];
	assign byte_sh = dmem_rdata >> {off, 3'b000};
	assign half_sh = dmem_rdata >> {off[1], 4'b0000};

	always_comb begin
		if (ld_sel_q[0]) begin
			load_val = {{24{byte_sh[7]}}, byte_sh[7:0]};
		end else if (ld_sel_q[1]) begin
			load_val = {{16{half_sh[15]}}, half_sh[15:0]};
		end else if (ld_sel_q[3]) begin
			load_val = {24'b0, byte_sh[7:0]};
		end else if (ld_sel_q[4]) begin
			load_val = {16'b0, half_sh[15:0]};
		end else begin
			load_val = dmem_rdata; // lw
		end
	end

	assign rd_data = (|ld_sel_q) ? load_val : wb_q;

endmodule

/* fetch_decode.sv */
`timescale 1ns/10ps
`include "rv_core_defs.svh"

module fetch_decode import rv_core_pkg::*; (
	input  logic              clk,
	input  logic              reset,
	input  logic [`XLEN-1:0]  imem_data,
	input  logic              jump,
	input  logic [`XLEN-1:0]  jump_target,
	output logic [`XLEN-1:0]  imem_addr,
	output logic              phase,
	exec_bus_if.dec           bus
);

	logic [`XLEN-1:0]     pc_q;
	logic [`XLEN-1:0]     instr;
	opcode_e               opc;
	logic [2:0]           funct3;
	logic [6:0]           funct7;
	op_idx_e               sel;
	logic                 hit;
	logic [`OP_BUS_W-1:0] ops;

	// pc moves only at the end of write-back
	always_ff @(posedge clk) begin
		if (reset) begin
			pc_q  <= '0;
			phase <= 1'b0;
		end else begin
			phase <= ~phase;
			if (phase) begin
				pc_q <= jump ? jump_target : pc_q + `XLEN'd4;
			end
		end
	end

	assign imem_addr = pc_q;
	assign instr     = imem_data; // stable over both phases
	assign opc       = opcode_e'(instr[6:0]);
	assign funct3    = instr[14:12];
	assign funct7    = instr[31:25];

	assign bus.pc       = pc_q;
	assign bus.opcode   = opc;
	assign bus.rs1_addr = instr[19:15];
	assign bus.rs2_addr = instr[24:20];
	assign bus.rd_addr  = instr[11:7];

	// immediate by format
	always_comb begin
		case (opc)
			opc_store:          bus.imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			opc_branch:         bus.imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
				instr[11:8], 1'b0};
			opc_lui, opc_auipc: bus.imm = {instr[31:12], 12'b0};
			opc_jal:            bus.imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
				instr[30:21], 1'b0};
			default:            bus.imm = {{20{instr[31]}}, instr[31:20]}; // I type
		endcase
	end

	// pick the one-hot position, no hit means retire as a bubble
	always_comb begin
		hit = 1'b1;
		sel = op_add;
		case (opc)
			opc_op: begin
				case ({funct7, funct3})
					{7'h00, 3'd0}: sel = op_add;
					{7'h20, 3'd0}: sel = op_sub;
					{7'h00, 3'd1}: sel = op_sll;
					{7'h00, 3'd2}: sel = op_slt;
					{7'h00, 3'd3}: sel = op_sltu;
					{7'h00, 3'd4}: sel = op_xor;
					{7'h00, 3'd5}: sel = op_srl;
					{7'h20, 3'd5}: sel = op_sra;
					{7'h00, 3'd6}: sel = op_or;
					{7'h00, 3'd7}: sel = op_and;
					default:       hit = 1'b0;
				endcase
			end
			opc_op_imm: begin
				case (funct3)
					3'd0: sel = op_addi;
					3'd2: sel = op_slti;
					3'd3: sel = op_sltiu;
					3'd4: sel = op_xori;
					3'd6: sel = op_ori;
					3'd7: sel = op_andi;
					3'd1: begin
						sel = op_slli;
						hit = (funct7 == 7'h00);
					end
					default: begin // funct3 5
						sel = (funct7 == 7'h20) ? op_srai : op_srli;
						hit = (funct7 == 7'h00) || (funct7 == 7'h20);
					end
				endcase
			end
			opc_load: begin
				case (funct3)
					3'd0:    sel = op_lb;
					3'd1:    sel = op_lh;
					3'd2:    sel = op_lw;
					3'd4:    sel = op_lbu;
					3'd5:    sel = op_lhu;
					default: hit = 1'b0;
				endcase
			end
			opc_store: begin
				case (funct3)
					3'd0:    sel = op_sb;
					3'd1:    sel = op_sh;
					3'd2:    sel = op_sw;
					default: hit = 1'b0;
				endcase
			end
			opc_branch: begin
				case (funct3)
					3'd0:    sel = op_beq;
					3'd1:    sel = op_bne;
					3'd4:    sel = op_blt;
					3'd5:    sel = op_bge;
					3'd6:    sel = op_bltu;
					3'd7:    sel = op_bgeu;
					default: hit = 1'b0;
				endcase
			end
			opc_jal:   sel = op_jal;
			opc_jalr: begin
				sel = op_jalr;
				hit = (funct3 == 3'd0);
			end
			opc_lui:   sel = op_lui;
			opc_auipc: sel = op_auipc;
			default:   hit = 1'b0;
		endcase
	end

	always_comb begin
		ops = '0;
		if (hit) begin
			ops[sel] = 1'b1;
		end
	end

	assign bus.op_bus = ops;

endmodule

/* filelist.f */
+incdir+.
rv_core_pkg.sv
exec_bus_if.sv
fetch_decode.sv
reg_file.sv
alu.sv
exec_control.sv
rv_core_top.sv
rv_core_asserts.sv
tb_rv_core.sv

/* reg_file.sv */
`timescale 1ns/10ps
`include "rv_core_defs.svh"

module reg_file (
	input  logic               clk,
	input  logic               reset,
	input  logic               we,
	input  logic [`REG_AW-1:0] wr_addr,
	input  logic [`XLEN-1:0]   wr_data,
	exec_bus_if.rf             bus
);

	logic [`XLEN-1:0] regs [`NUM_REGS];

	// single write port, x0 never written
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (wr_addr != '0)) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// async reads, x0 forced to zero
	assign bus.rs1_val = (bus.rs1_addr == '0) ? '0 : regs[bus.rs1_addr];
	assign bus.rs2_val = (bus.rs2_addr == '0) ? '0 : regs[bus.rs2_addr];

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build the core testbench with Verilator, run it, decide from the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f filelist.f --top-module tb_rv_core \
	-Mdir obj_dir -o sim_rv_core
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_rv_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qF "** PASS **" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1

/* rv_core_asserts.sv */
`timescale 1ns/10ps
`include "rv_core_defs.svh"

module rv_core_asserts (
	input logic               clk,
	input logic               reset,
	input logic               retire,
	input logic               rf_we,
	input logic               dmem_we,
	input logic [`REG_AW-1:0] rd_addr,
	input logic [`XLEN-1:0]   dmem_addr
);

	// one kind of write per instruction
	a_single_write: assert property (@(posedge clk) disable iff (reset)
		!(rf_we && dmem_we))
		else $error("rf_we and dmem_we high in the same cycle");

	a_no_x0_write: assert property (@(posedge clk) disable iff (reset)
		rf_we |-> (rd_addr != '0))
		else $error("register write strobe raised for x0");

	// two-cycle rhythm, retire toggles on every edge out of reset
	a_retire_rhythm: assert property (@(posedge clk) disable iff (reset)
		!$past(reset) |-> (retire != $past(retire)))
		else $error("retire did not toggle between cycles");

	a_store_range: assert property (@(posedge clk) disable iff (reset)
		dmem_we |-> (dmem_addr < `XLEN'(`DMEM_WORDS * 4)))
		else $error("store address outside data memory");

endmodule

bind rv_core_top rv_core_asserts asserts0 (.*);

/* rv_core_defs.svh */
`ifndef RV_CORE_DEFS_SVH
`define RV_CORE_DEFS_SVH

// data path and address width
`define XLEN 32

// one-hot operation bus, one bit per supported instruction
`define OP_BUS_W 37

// register file geometry
`define NUM_REGS 32
`define REG_AW 5

// data memory depth in 32-bit words
`define DMEM_WORDS 256

`endif

/* rv_core_pkg.sv */
package rv_core_pkg;

	// RV32I major opcodes handled by the core
	typedef enum logic [6:0] {
		opc_op     = 7'b0110011,
		opc_op_imm = 7'b0010011,
		opc_load   = 7'b0000011,
		opc_store  = 7'b0100011,
		opc_branch = 7'b1100011,
		opc_jal    = 7'b1101111,
		opc_jalr   = 7'b1100111,
		opc_lui    = 7'b0110111,
		opc_auipc  = 7'b0010111
	} opcode_e;

	// bit positions on the one-hot operation bus
	typedef enum logic [5:0] {
		op_add   = 6'd0,
		op_sub   = 6'd1,
		op_xor   = 6'd2,
		op_or    = 6'd3,
		op_and   = 6'd4,
		op_sll   = 6'd5,
		op_srl   = 6'd6,
		op_sra   = 6'd7,
		op_slt   = 6'd8,
		op_sltu  = 6'd9,
		op_addi  = 6'd10,
		op_xori  = 6'd11,
		op_ori   = 6'd12,
		op_andi  = 6'd13,
		op_slli  = 6'd14,
		op_srli  = 6'd15,
		op_srai  = 6'd16,
		op_slti  = 6'd17,
		op_sltiu = 6'd18,
		op_lb    = 6'd19, // loads 19..23
		op_lh    = 6'd20,
		op_lw    = 6'd21,
		op_lbu   = 6'd22,
		op_lhu   = 6'd23,
		op_sb    = 6'd24, // stores 24..26
		op_sh    = 6'd25,
		op_sw    = 6'd26,
		op_beq   = 6'd27, // branches 27..32
		op_bne   = 6'd28,
		op_blt   = 6'd29,
		op_bge   = 6'd30,
		op_bltu  = 6'd31,
		op_bgeu  = 6'd32,
		op_jal   = 6'd33,
		op_jalr  = 6'd34,
		op_lui   = 6'd35,
		op_auipc = 6'd36
	} op_idx_e;

endpackage

/* rv_core_top.sv */
`timescale 1ns/10ps
`include "rv_core_defs.svh"

module rv_core_top (
	input  logic               clk,
	input  logic               reset,
	output logic [`XLEN-1:0]   imem_addr,
	input  logic [`XLEN-1:0]   imem_data,
	output logic [`XLEN-1:0]   dmem_addr,
	output logic [`XLEN-1:0]   dmem_wdata,
	output logic [3:0]         dmem_be,
	output logic               dmem_we,
	input  logic [`XLEN-1:0]   dmem_rdata,
	output logic               retire,
	output logic               rf_we,
	output logic [`REG_AW-1:0] rd_addr,
	output logic [`XLEN-1:0]   rd_data
);

	logic             phase;
	logic             jump;
	logic [`XLEN-1:0] jump_target;

	exec_bus_if bus_i ();

	fetch_decode fd0 (
		.clk         (clk),
		.reset       (reset),
		.imem_data   (imem_data),
		.jump        (jump),
		.jump_target (jump_target),
		.imem_addr   (imem_addr),
		.phase       (phase),
		.bus         (bus_i.dec)
	);

	reg_file rf0 (
		.clk     (clk),
		.reset   (reset),
		.we      (rf_we),
		.wr_addr (bus_i.rd_addr),
		.wr_data (rd_data),
		.bus     (bus_i.rf)
	);

	exec_control ex0 (
		.clk         (clk),
		.reset       (reset),
		.phase       (phase),
		.bus         (bus_i.exe),
		.dmem_rdata  (dmem_rdata),
		.dmem_addr   (dmem_addr),
		.dmem_wdata  (dmem_wdata),
		.dmem_be     (dmem_be),
		.dmem_we     (dmem_we),
		.jump        (jump),
		.jump_target (jump_target),
		.rf_we       (rf_we),
		.rd_data     (rd_data),
		.retire      (retire)
	);

	assign rd_addr = bus_i.rd_addr; // trace of the destination

endmodule

/* tb_rv_core.sv */
`timescale 1ns/10ps
`include "rv_core_defs.svh"

module tb_rv_core;

	localparam logic [6:0] OP_R = 7'h33;
	localparam logic [6:0] OP_I = 7'h13;
	localparam logic [6:0] OP_LD = 7'h03;
	localparam logic [6:0] OP_LUI = 7'h37;
	localparam logic [6:0] OP_AUIPC = 7'h17;
	localparam logic [6:0] OP_JALR = 7'h67;
	localparam int K_RD = 0; // rd gets a fixed value
	localparam int K_LD = 1; // rd gets a value from the memory model
	localparam int K_ST = 2;
	localparam int K_PC = 3; // no write, next pc only

	logic        clk;
	logic        reset;
	logic [31:0] imem_addr;
	logic [31:0] imem_data;
	logic [31:0] dmem_addr;
	logic [31:0] dmem_wdata;
	logic [3:0]  dmem_be;
	logic        dmem_we;
	logic [31:0] dmem_rdata;
	logic        retire;
	logic        rf_we;
	logic [4:0]  rd_addr;
	logic [31:0] rd_data;

	logic [31:0] dmem [`DMEM_WORDS];

	string       t_name [$];
	logic [31:0] t_pc [$];
	logic [31:0] t_instr [$];
	int          t_kind [$];
	logic [4:0]  t_rd [$];
	logic [31:0] t_val [$];
	logic [31:0] t_addr [$];
	logic [3:0]  t_be [$];
	logic [31:0] t_next [$];
	logic [31:0] cur_pc;
	int          passed;
	int          failed;
	bit          row_bad;
	bit          timed_out;

	rv_core_top dut0 (
		.clk        (clk),
		.reset      (reset),
		.imem_addr  (imem_addr),
		.imem_data  (imem_data),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata),
		.dmem_be    (dmem_be),
		.dmem_we    (dmem_we),
		.dmem_rdata (dmem_rdata),
		.retire     (retire),
		.rf_we      (rf_we),
		.rd_addr    (rd_addr),
		.rd_data    (rd_data)
	);

	always #5 clk = ~clk;

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, OP_R};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
	endfunction

	function automatic int word_idx(input logic [31:0] a);
		return (a >> 2) % `DMEM_WORDS;
	endfunction

	function automatic logic [31:0] fetch_word(input logic [31:0] addr);
		logic [31:0] w;
		w = 32'h0000_0013; // nop outside the program
		foreach (t_pc[i]) begin
			if (t_pc[i] == addr) begin
				w = t_instr[i];
			end
		end
		return w;
	endfunction

	// byte and halfword extraction by the ISA load rules
	function automatic logic [31:0] load_expect(input logic [31:0] addr, input logic [2:0] f3);
		logic [31:0] w;
		logic [7:0]  b;
		logic [15:0] h;
		w = dmem[word_idx(addr)];
		b = w[8*addr[1:0] +: 8];
		h = w[16*addr[1] +: 16];
		case (f3)
			3'd0:    return {{24{b[7]}}, b};
			3'd1:    return {{16{h[15]}}, h};
			3'd4:    return {24'b0, b};
			3'd5:    return {16'b0, h};
			default: return w;
		endcase
	endfunction

	// memories answer a little after the edge
	always @(posedge clk) begin
		#1;
		imem_data  = fetch_word(imem_addr);
		dmem_rdata = dmem[word_idx(dmem_addr)];
	end

	always @(negedge clk) begin
		if (dmem_we === 1'b1) begin
			for (int b = 0; b < 4; b++) begin
				if (dmem_be[b]) begin
					dmem[word_idx(dmem_addr)][8*b +: 8] = dmem_wdata[8*b +: 8];
				end
			end
		end
	end

	task automatic add_row(input string name, input logic [31:0] instr, input int kind,
		input logic [4:0] rd, input logic [31:0] val, input logic [31:0] addr,
		input logic [3:0] be, input logic [31:0] nxt);
		t_name.push_back(name);
		t_pc.push_back(cur_pc);
		t_instr.push_back(instr);
		t_kind.push_back(kind);
		t_rd.push_back(rd);
		t_val.push_back(val);
		t_addr.push_back(addr);
		t_be.push_back(be);
		t_next.push_back(nxt);
		cur_pc = nxt;
	endtask

	task automatic rd_row(input string name, input logic [31:0] instr, input logic [4:0] rd,
		input logic [31:0] val);
		add_row(name, instr, K_RD, rd, val, 32'd0, 4'd0, cur_pc + 32'd4);
	endtask

	task automatic ld_row(input string name, input logic [31:0] instr, input logic [4:0] rd,
		input logic [31:0] addr);
		add_row(name, instr, K_LD, rd, {29'b0, instr[14:12]}, addr, 4'd0, cur_pc + 32'd4);
	endtask

	task automatic st_row(input string name, input logic [31:0] instr, input logic [31:0] addr,
		input logic [3:0] be, input logic [31:0] data);
		add_row(name, instr, K_ST, 5'd0, data, addr, be, cur_pc + 32'd4);
	endtask

	task automatic pc_row(input string name, input logic [31:0] instr, input logic [31:0] nxt);
		add_row(name, instr, K_PC, 5'd0, 32'd0, 32'd0, 4'd0, nxt);
	endtask

	// x2 = 5 and x3 = -3 make signed and unsigned compares disagree
	task automatic build_program();
		logic [31:0] link30;
		logic [31:0] link31;
		cur_pc = 32'd0;
		rd_row("lui", enc_i(12'h000, 5'd0, 3'd0, 5'd1, OP_LUI) | 32'h8000_0000, 5'd1, 32'h8000_0000);
		rd_row("addi", enc_i(12'd5, 5'd0, 3'd0, 5'd2, OP_I), 5'd2, 32'd5);
		rd_row("addi neg", enc_i(12'hffd, 5'd0, 3'd0, 5'd3, OP_I), 5'd3, 32'hffff_fffd);
		rd_row("add", enc_r(7'h00, 5'd3, 5'd2, 3'd0, 5'd4), 5'd4, 32'd2);
		rd_row("sub", enc_r(7'h20, 5'd3, 5'd2, 3'd0, 5'd5), 5'd5, 32'd8);
		rd_row("and", enc_r(7'h00, 5'd3, 5'd2, 3'd7, 5'd6), 5'd6, 32'd5);
		rd_row("or", enc_r(7'h00, 5'd3, 5'd2, 3'd6, 5'd7), 5'd7, 32'hffff_fffd);
		rd_row("xor", enc_r(7'h00, 5'd3, 5'd2, 3'd4, 5'd8), 5'd8, 32'hffff_fff8);
		rd_row("slt", enc_r(7'h00, 5'd2, 5'd3, 3'd2, 5'd9), 5'd9, 32'd1);
		rd_row("sltu", enc_r(7'h00, 5'd2, 5'd3, 3'd3, 5'd10), 5'd10, 32'd0);
		rd_row("sll", enc_r(7'h00, 5'd2, 5'd2, 3'd1, 5'd11), 5'd11, 32'h0000_00a0);
		rd_row("srl", enc_r(7'h00, 5'd2, 5'd1, 3'd5, 5'd12), 5'd12, 32'h0400_0000);
		rd_row("sra", enc_r(7'h20, 5'd2, 5'd1, 3'd5, 5'd13), 5'd13, 32'hfc00_0000);
		rd_row("xori", enc_i(12'h00f, 5'd2, 3'd4, 5'd14, OP_I), 5'd14, 32'h0000_000a);
		rd_row("ori", enc_i(12'h010, 5'd2, 3'd6, 5'd15, OP_I), 5'd15, 32'h0000_0015);
		rd_row("andi", enc_i(12'h00f, 5'd3, 3'd7, 5'd16, OP_I), 5'd16, 32'h0000_000d);
		rd_row("slti", enc_i(12'h000, 5'd3, 3'd2, 5'd17, OP_I), 5'd17, 32'd1);
		rd_row("sltiu", enc_i(12'h001, 5'd3, 3'd3, 5'd18, OP_I), 5'd18, 32'd0);
		rd_row("slli", enc_i(12'h004, 5'd2, 3'd1, 5'd19, OP_I), 5'd19, 32'h0000_0050);
		rd_row("srli", enc_i(12'h01f, 5'd1, 3'd5, 5'd20, OP_I), 5'd20, 32'd1);
		rd_row("srai", enc_i(12'h404, 5'd1, 3'd5, 5'd21, OP_I), 5'd21, 32'hf800_0000);
		rd_row("auipc", enc_i(12'h000, 5'd0, 3'd0, 5'd22, OP_AUIPC) | 32'h1234_5000, 5'd22,
			cur_pc + 32'h1234_5000);
		pc_row("addi to x0", enc_i(12'd7, 5'd2, 3'd0, 5'd0, OP_I), cur_pc + 32'd4);
		rd_row("x0 reads zero", enc_r(7'h00, 5'd2, 5'd0, 3'd0, 5'd23), 5'd23, 32'd5);
		rd_row("data base", enc_i(12'h100, 5'd0, 3'd0, 5'd24, OP_I), 5'd24, 32'h0000_0100);
		ld_row("lb", enc_i(12'd1, 5'd24, 3'd0, 5'd25, OP_LD), 5'd25, 32'h0000_0101);
		ld_row("lh", enc_i(12'd2, 5'd24, 3'd1, 5'd26, OP_LD), 5'd26, 32'h0000_0102);
		ld_row("lw", enc_i(12'd4, 5'd24, 3'd2, 5'd27, OP_LD), 5'd27, 32'h0000_0104);
		ld_row("lbu", enc_i(12'd3, 5'd24, 3'd4, 5'd28, OP_LD), 5'd28, 32'h0000_0103);
		ld_row("lhu", enc_i(12'd6, 5'd24, 3'd5, 5'd29, OP_LD), 5'd29, 32'h0000_0106);
		st_row("sb", enc_s(12'd9, 5'd8, 5'd24, 3'd0), 32'h0000_0109, 4'b0010, 32'h0000_f800);
		st_row("sh", enc_s(12'd10, 5'd3, 5'd24, 3'd1), 32'h0000_010a, 4'b1100, 32'hfffd_0000);
		st_row("sw", enc_s(12'd12, 5'd13, 5'd24, 3'd2), 32'h0000_010c, 4'b1111, 32'hfc00_0000);
		rd_row("lb after sb", enc_i(12'd9, 5'd24, 3'd0, 5'd25, OP_LD), 5'd25, 32'hffff_fff8);
		rd_row("lhu after sh", enc_i(12'd10, 5'd24, 3'd5, 5'd26, OP_LD), 5'd26, 32'h0000_fffd);
		rd_row("lh after sh", enc_i(12'd10, 5'd24, 3'd1, 5'd27, OP_LD), 5'd27, 32'hffff_fffd);
		rd_row("lw after sw", enc_i(12'd12, 5'd24, 3'd2, 5'd28, OP_LD), 5'd28, 32'hfc00_0000);
		rd_row("lbu after sb", enc_i(12'd9, 5'd24, 3'd4, 5'd29, OP_LD), 5'd29, 32'h0000_00f8);
		pc_row("blt taken", enc_b(13'd8, 5'd2, 5'd3, 3'd4), cur_pc + 32'd8);
		pc_row("bltu not taken", enc_b(13'd8, 5'd2, 5'd3, 3'd6), cur_pc + 32'd4);
		pc_row("bge not taken", enc_b(13'd8, 5'd2, 5'd3, 3'd5), cur_pc + 32'd4);
		pc_row("bgeu taken", enc_b(13'd8, 5'd2, 5'd3, 3'd7), cur_pc + 32'd8);
		pc_row("beq taken", enc_b(13'd8, 5'd23, 5'd2, 3'd0), cur_pc + 32'd8);
		pc_row("bne not taken", enc_b(13'd8, 5'd23, 5'd2, 3'd1), cur_pc + 32'd4);
		pc_row("bne taken", enc_b(13'd12, 5'd3, 5'd2, 3'd1), cur_pc + 32'd12);
		pc_row("blt not taken", enc_b(13'd8, 5'd3, 5'd2, 3'd4), cur_pc + 32'd4);
		pc_row("bltu taken", enc_b(13'd8, 5'd3, 5'd2, 3'd6), cur_pc + 32'd8);
		pc_row("bge taken", enc_b(13'd8, 5'd3, 5'd2, 3'd5), cur_pc + 32'd8);
		pc_row("bgeu not taken", enc_b(13'd8, 5'd3, 5'd2, 3'd7), cur_pc + 32'd4);
		pc_row("beq not taken", enc_b(13'd8, 5'd3, 5'd2, 3'd0), cur_pc + 32'd4);
		link30 = cur_pc + 32'd4;
		add_row("jal", enc_j(21'd12, 5'd30), K_RD, 5'd30, link30, 32'd0, 4'd0, cur_pc + 32'd12);
		link31 = cur_pc + 32'd4;
		add_row("jalr", enc_i(12'd21, 5'd30, 3'd0, 5'd31, OP_JALR), K_RD, 5'd31, link31,
			32'd0, 4'd0, (link30 + 32'd21) & ~32'd1); // target lsb cleared
		rd_row("addi after jalr", enc_i(12'd1, 5'd31, 3'd0, 5'd1, OP_I), 5'd1, link31 + 32'd1);
	endtask

	task automatic compare_val(input int i, input string what, input logic [31:0] exp,
		input logic [31:0] act);
		if (act !== exp) begin
			$display("error %s %s: expected %h actual %h", t_name[i], what, exp, act);
			row_bad = 1'b1;
		end
	endtask

	task automatic check_row(input int i);
		int n;
		n = 0;
		row_bad = 1'b0;
		do begin
			@(negedge clk);
			n++;
		end while (retire !== 1'b1 && n < 20);
		if (retire !== 1'b1) begin
			$display("%s: instruction did not retire within 20 cycles", t_name[i]);
			timed_out = 1'b1;
			failed++;
			return;
		end
		case (t_kind[i])
			K_RD, K_LD: begin
				compare_val(i, "rf_we", 32'd1, {31'b0, rf_we});
				compare_val(i, "rd_addr", {27'b0, t_rd[i]}, {27'b0, rd_addr});
				if (t_kind[i] == K_LD) begin
					compare_val(i, "dmem_addr", t_addr[i], dmem_addr);
					compare_val(i, "rd_data", load_expect(t_addr[i], t_val[i][2:0]), rd_data);
				end else begin
					compare_val(i, "rd_data", t_val[i], rd_data);
				end
			end
			K_ST: begin
				compare_val(i, "dmem_we", 32'd1, {31'b0, dmem_we});
				compare_val(i, "rf_we", 32'd0, {31'b0, rf_we});
				compare_val(i, "dmem_addr", t_addr[i], dmem_addr);
				compare_val(i, "dmem_be", {28'b0, t_be[i]}, {28'b0, dmem_be});
				compare_val(i, "dmem_wdata", t_val[i], dmem_wdata);
			end
			default: begin
				compare_val(i, "rf_we", 32'd0, {31'b0, rf_we});
				compare_val(i, "dmem_we", 32'd0, {31'b0, dmem_we});
			end
		endcase
		@(negedge clk); // next fetch is on the bus by now
		compare_val(i, "next pc", t_next[i], imem_addr);
		if (row_bad) begin
			$display("test %s failed", t_name[i]);
			failed++;
		end else begin
			$display("test %s ok", t_name[i]);
			passed++;
		end
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		imem_data = 32'h0000_0013;
		dmem_rdata = 32'd0;
		passed = 0;
		failed = 0;
		timed_out = 1'b0;
		void'($urandom(27));
		foreach (dmem[i]) begin
			dmem[i] = $urandom;
		end
		build_program();
		repeat (2) @(posedge clk);
		#1 reset = 1'b0;
		for (int i = 0; i < t_name.size() && !timed_out; i++) begin
			check_row(i);
		end
		$display("%0d tests run, %0d passed, %0d failed", passed + failed, passed, failed);
		if (failed == 0 && !timed_out) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule
